/* Bender.yml */
package:
  name: softmax_stats

export_include_dirs:
  - logic

sources:
  - logic/softmax_data_pkg.sv
  - logic/softmax_ctrl_pkg.sv
  - logic/softmax_stage_if.sv
  - logic/row_ram.sv
  - logic/softmax_sequencer.sv
  - logic/exp_shift_unit.sv
  - logic/max_store.sv
  - logic/exp_sum_accum.sv
  - logic/softmax_stats_top.sv
  - target: test
    files:
      - bench/softmax_stats_assert.sv
      - bench/tb_softmax_stats.sv

/* bench/softmax_stats_assert.sv */
/*
 * Bound assertions on the softmax row statistics top level
 */
`timescale 1ns/10ps

module softmax_stats_assert (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   sum_valid_i,
  input softmax_ctrl_pkg::row_t sum_row_i,
  input logic                   tok_valid_i,
  input logic                   tok_last_i
);

  no_result_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !sum_valid_i)
    else $error("sum_valid_o high while in reset");

  // Token is one cycle behind the sampled beat
  last_beat_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tok_valid_i && tok_last_i |-> ##2 sum_valid_i)
    else $error("no result 3 cycles after a last beat");

  result_has_last_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sum_valid_i |-> $past(tok_valid_i && tok_last_i, 2))
    else $error("result without a last beat 3 cycles before");

  // Back-to-back results come from consecutive rows
  consecutive_rows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sum_valid_i && $past(sum_valid_i) |-> sum_row_i == softmax_ctrl_pkg::row_t'($past(sum_row_i) + 1))
    else $error("consecutive results not from consecutive rows");

endmodule

bind softmax_stats_top softmax_stats_assert i_softmax_stats_assert (
  .clk_i       (clk_i           ),
  .rst_ni      (rst_ni          ),
  .sum_valid_i (sum_valid_o     ),
  .sum_row_i   (sum_row_o       ),
  .tok_valid_i (i_stage_if.valid),
  .tok_last_i  (i_stage_if.last )
);

/* bench/tb_softmax_stats.sv */
/*
 * Testbench for the softmax row statistics unit
 * Table-driven passes checked against a row model of max and exponent sums
 */
`timescale 1ns/10ps
`include "softmax_cfg.svh"

module tb_softmax_stats;

  localparam int unsigned seed = 32'h8f59_d63f;
  localparam int num_tests = 8;

  typedef struct packed {
    logic [2:0]  tiles;
    logic [7:0]  seq_len;
    logic        rand_mask;
    logic        rand_data;
    logic [1:0]  passes;
    logic        reset_mid;
    logic [15:0] directed;
  } test_t;

  // tiles, seq_len, random mask, random data, passes, reset mid-pass, directed sum
  localparam test_t test_table [num_tests] = '{
    '{3'd1, 8'd255, 1'b0, 1'b0, 2'd1, 1'b0, 16'd2048},
    '{3'd1, 8'd255, 1'b0, 1'b1, 2'd1, 1'b0, 16'd0},
    '{3'd2, 8'd255, 1'b0, 1'b1, 2'd1, 1'b0, 16'd0},
    '{3'd4, 8'd255, 1'b0, 1'b1, 2'd1, 1'b0, 16'd0},
    '{3'd3, 8'd13,  1'b0, 1'b1, 2'd1, 1'b0, 16'd0},
    '{3'd2, 8'd32,  1'b1, 1'b1, 2'd1, 1'b0, 16'd0},
    '{3'd2, 8'd255, 1'b0, 1'b1, 2'd3, 1'b0, 16'd0},
    '{3'd2, 8'd255, 1'b1, 1'b1, 2'd1, 1'b1, 16'd0}
  };

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic                         beat_valid;
  softmax_data_pkg::beat_t      beat;
  softmax_data_pkg::elem_t      max_in;
  softmax_data_pkg::mask_t      mask;
  softmax_ctrl_pkg::tile_t      num_tiles;
  softmax_ctrl_pkg::seq_len_t   seq_len;
  logic                         sum_valid;
  softmax_ctrl_pkg::row_t       sum_row;
  softmax_data_pkg::acc_t       sum;
  softmax_data_pkg::elem_t      row_max;

  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int results = 0;

  // Row model state
  softmax_data_pkg::elem_t run_max [`SM_ROWS];
  int                      run_sum [`SM_ROWS];

  // Results still expected, in arrival order
  softmax_data_pkg::acc_t  pend_sum [$];
  softmax_data_pkg::elem_t pend_max [$];
  softmax_ctrl_pkg::row_t  pend_row [$];
  int                      pend_due [$];

  softmax_stats_top i_softmax_stats_top (
    .clk_i        (clk       ),
    .rst_ni       (rst_n     ),
    .beat_valid_i (beat_valid),
    .beat_i       (beat      ),
    .max_i        (max_in    ),
    .mask_i       (mask      ),
    .num_tiles_i  (num_tiles ),
    .seq_len_i    (seq_len   ),
    .sum_valid_o  (sum_valid ),
    .sum_row_o    (sum_row   ),
    .sum_o        (sum       ),
    .row_max_o    (row_max   )
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic int round_div32(input int d);
    return (d + 16) / 32;
  endfunction

  task automatic check_sum(input softmax_data_pkg::acc_t got, input softmax_data_pkg::acc_t exp,
                           input int row);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: row %0d sum %0d, expected %0d", $time, row, got, exp);
      errors++;
    end
  endtask

  task automatic check_max(input softmax_data_pkg::elem_t got,
                           input softmax_data_pkg::elem_t exp, input int row);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: row %0d maximum %0d, expected %0d", $time, row, got, exp);
      errors++;
    end
  endtask

  task automatic match_row(input softmax_ctrl_pkg::row_t got, input softmax_ctrl_pkg::row_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: result row %0d, expected row %0d", $time, got, exp);
      errors++;
    end
  endtask

  // Drives one beat and advances the row model by the same rules
  task automatic drive_beat(input test_t t, input int tile, input int chunk, input int row);
    softmax_data_pkg::beat_t b;
    softmax_data_pkg::mask_t m;
    softmax_data_pkg::elem_t bmax;
    softmax_data_pkg::elem_t nmax;
    logic first;
    logic last;
    int terms;
    int prev;
    int col;
    @(posedge clk);
    #2;
    first = (tile == 0) && (chunk == 0);
    last = (tile == t.tiles - 1) && (chunk == `SM_CHUNKS - 1);
    m = t.rand_mask ? softmax_data_pkg::mask_t'($urandom) : '0;
    for (int i = 0; i < `SM_N; i++) begin
      b[i] = t.rand_data ? softmax_data_pkg::elem_t'($urandom_range(255, 0)) : 8'sd37;
    end
    bmax = b[0];
    for (int i = 1; i < `SM_N; i++) begin
      if (b[i] > bmax) bmax = b[i];
    end
    nmax = (first || bmax > run_max[row]) ? bmax : run_max[row];
    terms = 0;
    for (int i = 0; i < `SM_N; i++) begin
      col = tile * `SM_N * `SM_CHUNKS + chunk * `SM_N + i;
      if (col < int'(t.seq_len) && !m[i]) begin
        terms += 256 >> round_div32(int'(nmax) - int'(b[i]));
      end
    end
    prev = first ? 0 : run_sum[row] >> round_div32(int'(nmax) - int'(run_max[row]));
    run_sum[row] = terms + prev;
    run_max[row] = nmax;
    beat_valid = 1'b1;
    beat = b;
    max_in = nmax;
    mask = m;
    if (last) begin
      pend_sum.push_back((t.directed != 0) ? t.directed : softmax_data_pkg::acc_t'(run_sum[row]));
      pend_max.push_back(nmax);
      pend_row.push_back(softmax_ctrl_pkg::row_t'(row));
      // Sampled on the next edge, visible after the third edge from there
      pend_due.push_back(cyc + 3);
    end
  endtask

  // Drives the first beats of a pass in chunk-major order
  task automatic run_pass(input test_t t, input int beats);
    int n;
    n = 0;
    for (int tile = 0; tile < t.tiles; tile++) begin
      for (int chunk = 0; chunk < `SM_CHUNKS; chunk++) begin
        for (int row = 0; row < `SM_ROWS; row++) begin
          if (n < beats) begin
            drive_beat(t, tile, chunk, row);
          end
          n++;
        end
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    beat_valid = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic drain_results();
    @(posedge clk);
    #2;
    beat_valid = 1'b0;
    while (pend_sum.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    #2;
  endtask

  always @(negedge clk) begin
    softmax_ctrl_pkg::row_t exp_row;
    int due;
    if (sum_valid) begin
      if (pend_sum.size() == 0) begin
        $display("Error at %0t: result for row %0d arrived with no last beat pending",
                 $time, sum_row);
        errors++;
      end else begin
        exp_row = pend_row.pop_front();
        due = pend_due.pop_front();
        results++;
        match_row(sum_row, exp_row);
        check_sum(sum, pend_sum.pop_front(), exp_row);
        check_max(row_max, pend_max.pop_front(), exp_row);
        if (cyc != due) begin
          $display("Fail at %0t: row %0d result in cycle %0d, expected cycle %0d",
                   $time, exp_row, cyc, due);
          errors++;
        end
      end
    end
  end

  initial begin
    int total;
    int err_before;
    int res_before;
    int pass_beats;
    test_t t;
    rst_n = 1'b0;
    beat_valid = 1'b0;
    beat = '0;
    max_in = '0;
    mask = '0;
    num_tiles = '0;
    seq_len = '0;
    void'($urandom(seed));
    total = 20;
    for (int k = 0; k < num_tests; k++) begin
      total += (test_table[k].passes + test_table[k].reset_mid) * test_table[k].tiles
               * `SM_CHUNKS * `SM_ROWS + 40;
    end
    fork
      begin
        #((total + 100) * 20);
        $display("Timeout: the tests did not finish within %0d cycles", total + 100);
        $display("Simulation failed");
        $finish;
      end
    join_none
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int k = 0; k < num_tests; k++) begin
      t = test_table[k];
      err_before = errors;
      res_before = results;
      pass_beats = t.tiles * `SM_CHUNKS * `SM_ROWS;
      num_tiles = softmax_ctrl_pkg::tile_t'(t.tiles - 1);
      seq_len = t.seq_len;
      if (t.reset_mid) begin
        // Stop three beats short so some last beats are still in the pipeline
        run_pass(t, pass_beats - 3);
        apply_reset();
        // Results of the three beats cut off by the reset never arrive
        repeat (3) begin
          void'(pend_sum.pop_back());
          void'(pend_max.pop_back());
          void'(pend_row.pop_back());
          void'(pend_due.pop_back());
        end
      end
      for (int p = 0; p < t.passes; p++) begin
        run_pass(t, pass_beats);
      end
      drain_results();
      $display("Test %0d: %0d tiles, seq_len %0d, %0d results, %0d errors",
               k, t.tiles, t.seq_len, results - res_before, errors - err_before);
    end
    $display("Tests %0d, results %0d, checks %0d, errors %0d", num_tests, results, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* logic/exp_shift_unit.sv */
/*
 * Per-element column disabling and power-of-two exponent shifts
 */
`timescale 1ns/10ps
`include "softmax_cfg.svh"

module exp_shift_unit (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  softmax_stage_if.sink                tok_i,
  input  softmax_data_pkg::beat_t      beat_i,
  input  softmax_data_pkg::elem_t      max_i,
  input  softmax_data_pkg::mask_t      mask_i,
  input  softmax_ctrl_pkg::seq_len_t   seq_len_i,
  output softmax_data_pkg::shift_vec_t shift_o,
  output logic                         shift_valid_o
);

  softmax_data_pkg::beat_t      beat_q;
  softmax_data_pkg::elem_t      max_q;
  softmax_data_pkg::mask_t      mask_q;
  logic [`SM_N-1:0][`SM_SEQ_W:0] col;
  logic [`SM_N-1:0]             disable_el;
  softmax_data_pkg::shift_vec_t shift_d;

  // Stage 0 capture, qualified later by the token
  always_ff @(posedge clk_i) begin
    beat_q <= beat_i;
    max_q  <= max_i;
    mask_q <= mask_i;
  end

  always_comb begin
    for (int i = 0; i < `SM_N; i++) begin
      col[i]        = (`SM_SEQ_W + 1)'(tok_i.tile_col + i);
      disable_el[i] = mask_q[i] || (col[i] >= {1'b0, seq_len_i});
      shift_d[i]    = disable_el[i] ? softmax_data_pkg::shift_off
                    : softmax_data_pkg::round_shift(8'(max_q - beat_q[i]));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_valid_o <= 1'b0;
    end else begin
      shift_valid_o <= tok_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    shift_o <= shift_d;
  end

endmodule

/* logic/exp_sum_accum.sv */
/*
 * Row sum memory and accumulation of exponent terms
 * Writes partial sums back and emits the final sum on the last beat
 */
`timescale 1ns/10ps
`include "softmax_cfg.svh"

module exp_sum_accum (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  softmax_data_pkg::shift_vec_t shift_i,
  input  logic                         shift_valid_i,
  input  softmax_data_pkg::shift_t     sum_shift_i,
  input  softmax_ctrl_pkg::row_t       row_i,
  input  logic                         first_i,
  input  logic                         last_i,
  input  logic                         valid_i,
  input  softmax_data_pkg::elem_t      max_i,
  output logic                         sum_valid_o,
  output softmax_ctrl_pkg::row_t       sum_row_o,
  output softmax_data_pkg::acc_t       sum_o,
  output softmax_data_pkg::elem_t      row_max_o
);

  softmax_data_pkg::acc_t  stored_sum;
  softmax_data_pkg::acc_t  term_sum;
  softmax_data_pkg::acc_t  prev_sum;
  softmax_data_pkg::acc_t  sum_q;
  softmax_ctrl_pkg::row_t  row_q;
  softmax_data_pkg::elem_t max_q;
  logic                    valid_q;
  logic                    last_q;

  always_comb begin
    term_sum = '0;
    for (int i = 0; i < `SM_N; i++) begin
      if (shift_i[i] != softmax_data_pkg::shift_off) begin
        term_sum = term_sum + softmax_data_pkg::acc_t'(9'h100 >> shift_i[i]);
      end
    end
    // Previous sum rescaled to the new maximum
    prev_sum = first_i ? '0 : (stored_sum >> sum_shift_i);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i && shift_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    sum_q  <= term_sum + prev_sum;
    row_q  <= row_i;
    last_q <= last_i;
    max_q  <= max_i;
  end

  row_ram #(
    .word_t (softmax_data_pkg::acc_t)
  ) i_sum_ram (
    .clk_i     (clk_i              ),
    .rst_ni    (rst_ni             ),
    .rd_addr_i (row_i              ),
    .rd_data_o (stored_sum         ),
    .wr_en_i   (valid_q && !last_q ),
    .wr_addr_i (row_q              ),
    .wr_data_i (sum_q              )
  );

  // Stage 3 emission
  assign sum_valid_o = valid_q && last_q;
  assign sum_row_o   = row_q;
  assign sum_o       = sum_q;
  assign row_max_o   = max_q;

endmodule

/* logic/max_store.sv */
/*
 * Row maximum memory and rescale shift of the previous row sum
 */
`timescale 1ns/10ps

module max_store (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  softmax_stage_if.sink            tok_i,
  input  softmax_data_pkg::elem_t  max_i,
  output softmax_data_pkg::shift_t sum_shift_o,
  output softmax_ctrl_pkg::row_t   row_o,
  output logic                     first_o,
  output logic                     last_o,
  output logic                     valid_o,
  output softmax_data_pkg::elem_t  max_o
);

  softmax_data_pkg::elem_t max_q;
  softmax_data_pkg::elem_t stored_max;
  softmax_data_pkg::elem_t prev_max;

  always_ff @(posedge clk_i) begin
    max_q <= max_i;
  end

  row_ram #(
    .word_t (softmax_data_pkg::elem_t)
  ) i_max_ram (
    .clk_i     (clk_i      ),
    .rst_ni    (rst_ni     ),
    .rd_addr_i (tok_i.row  ),
    .rd_data_o (stored_max ),
    .wr_en_i   (tok_i.valid),
    .wr_addr_i (tok_i.row  ),
    .wr_data_i (max_q      )
  );

  // No stored maximum yet at the start of a row
  assign prev_max = tok_i.first ? softmax_data_pkg::elem_min : stored_max;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= tok_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    sum_shift_o <= softmax_data_pkg::round_shift(8'(max_q - prev_max));
    row_o       <= tok_i.row;
    first_o     <= tok_i.first;
    last_o      <= tok_i.last;
    max_o       <= max_q;
  end

endmodule

/* logic/row_ram.sv */
/*
 * Per-row register memory, combinational read and synchronous write
 */
`timescale 1ns/10ps
`include "softmax_cfg.svh"

module row_ram #(
  parameter type word_t = logic [7:0]
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  softmax_ctrl_pkg::row_t rd_addr_i,
  output word_t                  rd_data_o,
  input  logic                   wr_en_i,
  input  softmax_ctrl_pkg::row_t wr_addr_i,
  input  word_t                  wr_data_i
);

  word_t mem_q [`SM_ROWS];

  assign rd_data_o = mem_q[rd_addr_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < `SM_ROWS; r++) begin
        mem_q[r] <= '0;
      end
    end else if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

/* logic/softmax_cfg.svh */
/*
 * Softmax row statistics configuration
 */
`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// Elements per score beat
`define SM_N 4
// Rows per tile, at least 3 so a row is never read while still being written
`define SM_ROWS 8
// Beats per row within one tile
`define SM_CHUNKS 2
`define SM_ACC_W 16
`define SM_MAX_TILES 4
`define SM_SEQ_W 8

`endif

/* logic/softmax_ctrl_pkg.sv */
/*
 * Softmax control types: row addresses, chunk and tile counters
 */
`include "softmax_cfg.svh"

package softmax_ctrl_pkg;

  typedef logic [$clog2(`SM_ROWS)-1:0] row_t;

  typedef logic [$clog2(`SM_CHUNKS)-1:0] chunk_t;

  // Tile index, also used for the last tile index of a pass
  typedef logic [$clog2(`SM_MAX_TILES)-1:0] tile_t;

  // Sequence length and absolute column index
  typedef logic [`SM_SEQ_W-1:0] seq_len_t;

endpackage

/* logic/softmax_data_pkg.sv */
/*
 * Softmax data types: scores, beats, exponent shifts and row sums
 */
`include "softmax_cfg.svh"

package softmax_data_pkg;

  typedef logic signed [7:0] elem_t;
  typedef elem_t [`SM_N-1:0] beat_t;
  typedef logic [3:0] shift_t;
  typedef shift_t [`SM_N-1:0] shift_vec_t;
  typedef logic [`SM_ACC_W-1:0] acc_t;
  typedef logic [`SM_N-1:0] mask_t;

  // Shift code of a disabled element
  localparam shift_t shift_off = 4'hF;
  localparam elem_t elem_min = 8'sh80;

  // Difference divided by 32, rounded half up
  function automatic shift_t round_shift(input logic [7:0] diff);
    logic [8:0] biased;
    biased = {1'b0, diff} + 9'd16;
    return shift_t'(biased >> 5);
  endfunction

endpackage

/* logic/softmax_sequencer.sv */
/*
 * Stage 0 sequencer: counts rows, chunks and tiles of incoming beats
 * and issues one stage token per beat
 */
`timescale 1ns/10ps
`include "softmax_cfg.svh"

module softmax_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    beat_valid_i,
  // Index of the last tile in a pass, tile count minus one
  input  softmax_ctrl_pkg::tile_t num_tiles_i,
  softmax_stage_if.seq            tok_o
);

  softmax_ctrl_pkg::row_t   row_q;
  softmax_ctrl_pkg::chunk_t chunk_q;
  softmax_ctrl_pkg::tile_t  tile_q;
  logic                     row_wrap;
  logic                     chunk_wrap;
  logic                     tile_wrap;

  assign row_wrap   = (row_q == softmax_ctrl_pkg::row_t'(`SM_ROWS - 1));
  assign chunk_wrap = (chunk_q == softmax_ctrl_pkg::chunk_t'(`SM_CHUNKS - 1));
  assign tile_wrap  = (tile_q == num_tiles_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q          <= '0;
      chunk_q        <= '0;
      tile_q         <= '0;
      tok_o.valid    <= 1'b0;
      tok_o.row      <= '0;
      tok_o.first    <= 1'b0;
      tok_o.last     <= 1'b0;
      tok_o.tile_col <= '0;
    end else begin
      tok_o.valid    <= beat_valid_i;
      tok_o.row      <= row_q;
      tok_o.first    <= (tile_q == '0) && (chunk_q == '0);
      tok_o.last     <= tile_wrap && chunk_wrap;
      tok_o.tile_col <= softmax_ctrl_pkg::seq_len_t'(tile_q * (`SM_N * `SM_CHUNKS)
                                                     + chunk_q * `SM_N);
      // Chunk-major order: all rows of a chunk, then the next chunk
      if (beat_valid_i) begin
        row_q <= row_wrap ? '0 : row_q + 1'b1;
        if (row_wrap) begin
          chunk_q <= chunk_wrap ? '0 : chunk_q + 1'b1;
          if (chunk_wrap) begin
            tile_q <= tile_wrap ? '0 : tile_q + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* logic/softmax_stage_if.sv */
/*
 * Softmax pipeline stage token
 * Row address and position flags of the beat entering stage 1
 */
`timescale 1ns/10ps

interface softmax_stage_if;

  logic                       valid;
  softmax_ctrl_pkg::row_t     row;
  // Tile 0, chunk 0
  logic                       first;
  // Last tile, last chunk
  logic                       last;
  // Column of element 0 of the beat
  softmax_ctrl_pkg::seq_len_t tile_col;

  modport seq (
    output valid, row, first, last, tile_col
  );

  modport sink (
    input valid, row, first, last, tile_col
  );

endinterface

/* logic/softmax_stats_top.sv */
/*
 * Softmax row statistics unit: running row maximum and exponent sum
 * over column tiles, final sum and maximum per row
 */
`timescale 1ns/10ps

module softmax_stats_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       beat_valid_i,
  input  softmax_data_pkg::beat_t    beat_i,
  // Running row maximum including the current beat
  input  softmax_data_pkg::elem_t    max_i,
  input  softmax_data_pkg::mask_t    mask_i,
  // Index of the last tile, tile count minus one
  input  softmax_ctrl_pkg::tile_t    num_tiles_i,
  input  softmax_ctrl_pkg::seq_len_t seq_len_i,
  output logic                       sum_valid_o,
  output softmax_ctrl_pkg::row_t     sum_row_o,
  output softmax_data_pkg::acc_t     sum_o,
  output softmax_data_pkg::elem_t    row_max_o
);

  softmax_data_pkg::shift_vec_t shift_vec;
  logic                         shift_valid;
  softmax_data_pkg::shift_t     sum_shift;
  softmax_ctrl_pkg::row_t       acc_row;
  logic                         acc_first;
  logic                         acc_last;
  logic                         acc_valid;
  softmax_data_pkg::elem_t      acc_max;

  softmax_stage_if i_stage_if ();

  softmax_sequencer i_sequencer (
    .clk_i        (clk_i       ),
    .rst_ni       (rst_ni      ),
    .beat_valid_i (beat_valid_i),
    .num_tiles_i  (num_tiles_i ),
    .tok_o        (i_stage_if  )
  );

  exp_shift_unit i_exp_shift (
    .clk_i         (clk_i      ),
    .rst_ni        (rst_ni     ),
    .tok_i         (i_stage_if ),
    .beat_i        (beat_i     ),
    .max_i         (max_i      ),
    .mask_i        (mask_i     ),
    .seq_len_i     (seq_len_i  ),
    .shift_o       (shift_vec  ),
    .shift_valid_o (shift_valid)
  );

  max_store i_max_store (
    .clk_i       (clk_i     ),
    .rst_ni      (rst_ni    ),
    .tok_i       (i_stage_if),
    .max_i       (max_i     ),
    .sum_shift_o (sum_shift ),
    .row_o       (acc_row   ),
    .first_o     (acc_first ),
    .last_o      (acc_last  ),
    .valid_o     (acc_valid ),
    .max_o       (acc_max   )
  );

  exp_sum_accum i_sum_accum (
    .clk_i         (clk_i      ),
    .rst_ni        (rst_ni     ),
    .shift_i       (shift_vec  ),
    .shift_valid_i (shift_valid),
    .sum_shift_i   (sum_shift  ),
    .row_i         (acc_row    ),
    .first_i       (acc_first  ),
    .last_i        (acc_last   ),
    .valid_i       (acc_valid  ),
    .max_i         (acc_max    ),
    .sum_valid_o   (sum_valid_o),
    .sum_row_o     (sum_row_o  ),
    .sum_o         (sum_o      ),
    .row_max_o     (row_max_o  )
  );

endmodule

/* sources.f */
+incdir+logic
logic/softmax_data_pkg.sv
logic/softmax_ctrl_pkg.sv
logic/softmax_stage_if.sv
logic/row_ram.sv
logic/softmax_sequencer.sv
logic/exp_shift_unit.sv
logic/max_store.sv
logic/exp_sum_accum.sv
logic/softmax_stats_top.sv
bench/softmax_stats_assert.sv
bench/tb_softmax_stats.sv
